/* src/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

    // Screen geometry
    localparam int num_cols = 16;
    localparam int num_rows = 2;

    localparam int powerup_periods = 10; // Strobe periods to wait after reset

    // HD44780 instruction bytes, 8-bit bus
    localparam logic [7:0] cmd_function_set = 8'h38; // 8-bit, two lines, 5x8 font
    localparam logic [7:0] cmd_display_off  = 8'h08;
    localparam logic [7:0] cmd_clear        = 8'h01;
    localparam logic [7:0] cmd_entry_mode   = 8'h06; // Increment, no shift
    localparam logic [7:0] cmd_display_on   = 8'h0C; // Cursor and blink off

    // DDRAM address of column 0 on each line
    localparam logic [7:0] cmd_row1_addr = 8'h80;
    localparam logic [7:0] cmd_row2_addr = 8'hC0;

    localparam logic [7:0] char_space = 8'h20;

endpackage

`default_nettype wire

/* src/text_pkg.sv */
`default_nettype none

package text_pkg;

    typedef logic [4:0] cell_addr_t; // {row, col}

    localparam logic op_char = 1'b0;
    localparam logic op_hex  = 1'b1;

    // Both views share op in bit 15 and row in bit 14
    typedef union packed {
        struct packed {
            logic       op;
            logic       row;
            logic [3:0] col;
            logic [1:0] rsvd;
            logic [7:0] code; // ASCII
        } ch;
        struct packed {
            logic        op;
            logic        row;
            logic [1:0]  slot;  // Four-column field
            logic [11:0] value;
        } hex;
    } host_word_t;

endpackage

`default_nettype wire

/* src/text_formatter.sv */
`default_nettype none

module text_formatter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 host_valid,
    output logic                 host_ready,
    input  text_pkg::host_word_t host_word,
    output logic                 cell_we,
    output text_pkg::cell_addr_t cell_addr,
    output logic [7:0]           cell_char
);
    import text_pkg::*;

    logic [11:0] digits;  // Remaining hex digits, next one on top
    logic [1:0]  pending; // Writes still owed after the first one
    logic        accept;

    function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};
        end else begin
            return 8'h37 + {4'h0, nib}; // 'A' - 10
        end
    endfunction

    // One word in flight at most
    assign host_ready = (pending == 2'd0);
    assign accept     = host_valid && host_ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            cell_we <= 1'b0;
            pending <= 2'd0;
        end else if (accept) begin
            cell_we <= 1'b1;
            case (host_word.ch.op)
                op_char: pending <= 2'd0;
                op_hex:  pending <= 2'd2; // Two more digits follow
            endcase
        end else if (pending != 2'd0) begin
            cell_we <= 1'b1;
            pending <= pending - 2'd1;
        end else begin
            cell_we <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            case (host_word.ch.op)
                op_char: begin
                    cell_addr <= {host_word.ch.row, host_word.ch.col};
                    cell_char <= host_word.ch.code;
                end
                op_hex: begin
                    // Field starts at column slot*4, high digit first
                    cell_addr <= {host_word.hex.row, host_word.hex.slot, 2'b00};
                    cell_char <= hex_ascii(host_word.hex.value[11:8]);
                    digits    <= {host_word.hex.value[7:0], 4'h0};
                end
            endcase
        end else if (pending != 2'd0) begin
            cell_addr <= cell_addr + 5'd1; // Stays inside the field
            cell_char <= hex_ascii(digits[11:8]);
            digits    <= digits << 4;
        end
    end

endmodule

`default_nettype wire

/* src/text_buffer.sv */
`default_nettype none

module text_buffer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cell_we,
    input  text_pkg::cell_addr_t            cell_addr,
    input  logic [7:0]                      cell_char,
    output logic [8*lcd_pkg::num_cols-1:0]  row_1,
    output logic [8*lcd_pkg::num_cols-1:0]  row_2
);
    import lcd_pkg::*;

    logic [7:0] cells [num_rows][num_cols];
    logic       wr_row;
    logic [3:0] wr_col;

    assign wr_row = cell_addr[4];
    assign wr_col = cell_addr[3:0];

    // Blank screen after reset
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int r = 0; r < num_rows; r++) begin
                for (int c = 0; c < num_cols; c++) begin
                    cells[r][c] <= char_space;
                end
            end
        end else if (cell_we) begin
            cells[wr_row][wr_col] <= cell_char;
        end
    end

    // Column 0 goes to the most significant byte
    always_comb begin
        for (int c = 0; c < num_cols; c++) begin
            row_1[8*(num_cols-1-c) +: 8] = cells[0][c];
            row_2[8*(num_cols-1-c) +: 8] = cells[1][c];
        end
    end

endmodule

`default_nettype wire

/* src/lcd_timing.sv */
`default_nettype none

module lcd_timing #(
    parameter int clk_div = 20000
) (
    input  logic clk,
    input  logic rst,
    output logic lcd_tick,
    output logic lcd_en
);
    import lcd_pkg::*;

    localparam int wait_cycles = powerup_periods * clk_div;
    localparam int wait_w      = $clog2(wait_cycles + 1);
    localparam int period_w    = $clog2(clk_div);

    logic [wait_w-1:0]   pwr_cnt;
    logic [period_w-1:0] period_cnt;
    logic                running;

    assign running = (pwr_cnt == wait_w'(wait_cycles)); // Power-up wait over

    always_ff @(posedge clk) begin
        if (!rst) begin
            pwr_cnt <= '0;
        end else if (!running) begin
            pwr_cnt <= pwr_cnt + 1'b1; // Saturates at wait_cycles
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            period_cnt <= '0;
        end else if (running) begin
            if (period_cnt == period_w'(clk_div - 1)) begin
                period_cnt <= '0;
            end else begin
                period_cnt <= period_cnt + 1'b1;
            end
        end
    end

    // Last wait cycle ticks too, so the first command is set up before the first strobe
    assign lcd_tick = running ? (period_cnt == period_w'(clk_div - 1))
                              : (pwr_cnt == wait_w'(wait_cycles - 1));
    assign lcd_en   = running && (period_cnt < period_w'(clk_div / 2)); // High in first half

endmodule

`default_nettype wire

/* src/lcd1602.sv */
`default_nettype none

module lcd1602 #(
    parameter int clk_div = 20000
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [8*lcd_pkg::num_cols-1:0] row_1,
    input  logic [8*lcd_pkg::num_cols-1:0] row_2,
    output logic                           lcd_en,
    output logic                           lcd_rw,
    output logic                           lcd_rs,
    output logic [7:0]                     lcd_data
);
    import lcd_pkg::*;

    // Phase encodings
    localparam logic [1:0] ph_init = 2'd0;
    localparam logic [1:0] ph_addr = 2'd1;
    localparam logic [1:0] ph_char = 2'd2;

    localparam logic [2:0] last_init = 3'd4; // Five init commands
    localparam logic [3:0] last_col  = 4'(num_cols - 1);

    logic       lcd_tick;
    logic [1:0] phase;
    logic [2:0] init_step;
    logic       row_sel;   // 0 selects row 1
    logic [3:0] col;
    logic [3:0] char_pos;
    logic [7:0] init_byte;
    logic [7:0] char_byte;

    lcd_timing #(
        .clk_div (clk_div)
    ) u_timing (
        .clk      (clk),
        .rst      (rst),
        .lcd_tick (lcd_tick),
        .lcd_en   (lcd_en)
    );

    always_comb begin
        case (init_step)
            3'd0:    init_byte = cmd_function_set;
            3'd1:    init_byte = cmd_display_off;
            3'd2:    init_byte = cmd_clear;
            3'd3:    init_byte = cmd_entry_mode;
            default: init_byte = cmd_display_on;
        endcase
    end

    // Column 0 sits in the top byte of the row vector
    assign char_pos  = last_col - col;
    assign char_byte = row_sel ? row_2[char_pos*8 +: 8] : row_1[char_pos*8 +: 8];

    // Advance one step per strobe period
    always_ff @(posedge clk) begin
        if (!rst) begin
            phase     <= ph_init;
            init_step <= 3'd0;
            row_sel   <= 1'b0;
            col       <= 4'd0;
        end else if (lcd_tick) begin
            case (phase)
                ph_init: begin
                    if (init_step == last_init) begin
                        phase <= ph_addr;
                    end else begin
                        init_step <= init_step + 3'd1;
                    end
                end
                ph_addr: begin
                    phase <= ph_char;
                    col   <= 4'd0;
                end
                ph_char: begin
                    if (col == last_col) begin
                        phase   <= ph_addr;
                        row_sel <= !row_sel; // Alternate rows forever
                    end
                    col <= col + 4'd1;
                end
                default: phase <= ph_init;
            endcase
        end
    end

    // Bus byte for the step being taken, held for the whole period
    always_ff @(posedge clk) begin
        if (!rst) begin
            lcd_rs   <= 1'b0;
            lcd_data <= 8'h00;
        end else if (lcd_tick) begin
            case (phase)
                ph_init: begin
                    lcd_rs   <= 1'b0;
                    lcd_data <= init_byte;
                end
                ph_addr: begin
                    lcd_rs   <= 1'b0; // Set DDRAM address
                    lcd_data <= row_sel ? cmd_row2_addr : cmd_row1_addr;
                end
                default: begin
                    lcd_rs   <= 1'b1;
                    lcd_data <= char_byte;
                end
            endcase
        end
    end

    assign lcd_rw = 1'b0; // Write only

endmodule

`default_nettype wire

/* src/lcd_text_top.sv */
`default_nettype none

module lcd_text_top #(
    parameter int clk_div = 20000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 host_valid,
    output logic                 host_ready,
    input  text_pkg::host_word_t host_word,
    output logic                 lcd_en,
    output logic                 lcd_rw,
    output logic                 lcd_rs,
    output logic [7:0]           lcd_data
);
    import text_pkg::*;
    import lcd_pkg::*;

    logic                  cell_we;
    cell_addr_t            cell_addr;
    logic [7:0]            cell_char;
    logic [8*num_cols-1:0] row_1;
    logic [8*num_cols-1:0] row_2;

    text_formatter u_formatter (
        .clk        (clk),
        .rst        (rst),
        .host_valid (host_valid),
        .host_ready (host_ready),
        .host_word  (host_word),
        .cell_we    (cell_we),
        .cell_addr  (cell_addr),
        .cell_char  (cell_char)
    );

    text_buffer u_buffer (
        .clk       (clk),
        .rst       (rst),
        .cell_we   (cell_we),
        .cell_addr (cell_addr),
        .cell_char (cell_char),
        .row_1     (row_1),
        .row_2     (row_2)
    );

    lcd1602 #(
        .clk_div (clk_div)
    ) u_lcd (
        .clk      (clk),
        .rst      (rst),
        .row_1    (row_1),
        .row_2    (row_2),
        .lcd_en   (lcd_en),
        .lcd_rw   (lcd_rw),
        .lcd_rs   (lcd_rs),
        .lcd_data (lcd_data)
    );

endmodule

`default_nettype wire

/* test/tb_lcd_text_top.sv */
`default_nettype none

module tb_lcd_text_top;
    timeunit 1ns;
    timeprecision 1ps;
    import text_pkg::*;

    localparam int clk_div       = 8;
    localparam int refresh_limit = 60 * clk_div; // Cycles allowed per refresh
    localparam int ready_limit   = 16;

    logic       clk;
    logic       rst;
    logic       host_valid;
    logic       host_ready;
    host_word_t host_word;
    logic       lcd_en;
    logic       lcd_rw;
    logic       lcd_rs;
    logic [7:0] lcd_data;

    logic [7:0] shadow [2][16]; // Screen as rebuilt from the bus
    int         byte_count    = 0;
    int         refresh_count = 0;
    int         pos;
    int         mon_row;
    int         mon_col;

    lcd_text_top #(
        .clk_div (clk_div)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .host_valid (host_valid),
        .host_ready (host_ready),
        .host_word  (host_word),
        .lcd_en     (lcd_en),
        .lcd_rw     (lcd_rw),
        .lcd_rs     (lcd_rs),
        .lcd_data   (lcd_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        abort_run();
    endtask

    function automatic logic [7:0] init_command(input int idx);
        case (idx)
            0:       return 8'h38;
            1:       return 8'h08;
            2:       return 8'h01;
            3:       return 8'h06;
            default: return 8'h0C;
        endcase
    endfunction

    function automatic logic [127:0] shadow_row(input int r);
        logic [127:0] v;
        for (int c = 0; c < 16; c++) begin
            v[8*(15-c) +: 8] = shadow[r][c]; // Column 0 in the top byte
        end
        return v;
    endfunction

    task automatic wait_refreshes(input int n);
        int target;
        int cycles;
        target = refresh_count + n;
        cycles = 0;
        while (refresh_count < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > n * refresh_limit) report_timeout("a full display refresh");
        end
    endtask

    task automatic send_word(input logic [15:0] word, output int stalls);
        logic accepted;
        accepted   = 1'b0;
        stalls     = 0;
        host_valid = 1'b1;
        host_word  = word;
        while (!accepted) begin
            @(negedge clk);
            if (host_ready) begin
                accepted = 1'b1; // Transfer on the coming edge
            end else begin
                stalls++;
                if (stalls > ready_limit) report_timeout("host_ready to go high");
            end
            @(posedge clk);
            #2;
        end
        host_valid = 1'b0;
    endtask

    // Latch on the falling strobe edge like the LCD
    always @(negedge lcd_en) begin
        if (rst) begin
            check_value(lcd_rw, 1'b0, "lcd_rw during a strobe");
            if (byte_count < 5) begin
                check_value({lcd_rs, lcd_data}, {1'b0, init_command(byte_count)},
                            "init command byte");
            end else begin
                pos = (byte_count - 5) % 34;
                if (pos == 0) begin
                    check_value({lcd_rs, lcd_data}, 9'h080, "row 1 address byte");
                end else if (pos == 17) begin
                    check_value({lcd_rs, lcd_data}, 9'h0C0, "row 2 address byte");
                end else begin
                    check_value(lcd_rs, 1'b1, "lcd_rs on a character byte");
                    mon_row = (pos > 17) ? 1 : 0;
                    mon_col = (pos > 17) ? pos - 18 : pos - 1;
                    shadow[mon_row][mon_col] = lcd_data;
                    if (pos == 33) refresh_count++;
                end
            end
            byte_count++;
        end
    end

    initial begin
        int           fd;
        int           r;
        int           gap;
        int           stalls;
        int           e_count;
        int           rnd;
        logic         prev_hex;
        logic [63:0]  tag;
        logic [1023:0] line;
        logic [15:0]  word_raw;
        logic [127:0] exp_row1;
        logic [127:0] exp_row2;

        rst        = 1'b0;
        host_valid = 1'b0;
        host_word  = 16'h0000;
        e_count    = 0;
        prev_hex   = 1'b0;
        rnd        = $urandom(32'he074_8701);
        for (int i = 0; i < 32; i++) begin
            shadow[i / 16][i % 16] = 8'h00;
        end

        repeat (3) @(posedge clk);
        #2;
        rst = 1'b1;

        repeat (10 * clk_div) @(posedge clk); // Power-up wait
        check_value(byte_count, 0, "strobe count during power-up wait");

        wait_refreshes(1);
        check_value(shadow_row(0), {16{8'h20}}, "row 1 after reset");
        check_value(shadow_row(1), {16{8'h20}}, "row 2 after reset");
        #2;

        fd = $fopen("test/lcd_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/lcd_testdata.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            r = $fscanf(fd, "%s", tag);
            if (r == 1) begin
                if (tag == "#") begin
                    r = $fgets(line, fd);
                end else if (tag == "W") begin
                    r = $fscanf(fd, "%h", word_raw);
                    if (r != 1) begin
                        $display("Could not read a host word from the test data file");
                        abort_run();
                    end
                    if (!prev_hex) begin
                        gap = $urandom % 4; // Hex words are followed back to back
                        if (gap > 0) begin
                            repeat (gap) @(posedge clk);
                            #2;
                        end
                    end
                    send_word(word_raw, stalls);
                    check_value(stalls, prev_hex ? 2 : 0, "host_ready low cycles");
                    prev_hex = word_raw[15];
                end else if (tag == "E") begin
                    r = $fscanf(fd, "%h %h", exp_row1, exp_row2);
                    if (r != 2) begin
                        $display("Could not read the expected rows from the test data file");
                        abort_run();
                    end
                    e_count++;
                    wait_refreshes(2);
                    check_value(shadow_row(0), exp_row1, $sformatf("row 1, E line %0d", e_count));
                    check_value(shadow_row(1), exp_row2, $sformatf("row 2, E line %0d", e_count));
                    prev_hex = 1'b0;
                    #2;
                end else begin
                    $display("Unknown line type in test data file");
                    abort_run();
                end
            end
        end
        $fclose(fd);

        wait_refreshes(3); // Long run so the monitor sees the refresh order repeat
        if (e_count == 0) begin
            $display("No expected screen rows found in the test data file");
            abort_run();
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* project.f */
src/lcd_pkg.sv
src/text_pkg.sv
src/text_formatter.sv
src/text_buffer.sv
src/lcd_timing.sv
src/lcd1602.sv
src/lcd_text_top.sv
test/tb_lcd_text_top.sv

/* Bender.yml */
package:
  name: lcd_text

sources:
  - src/lcd_pkg.sv
  - src/text_pkg.sv
  - src/text_formatter.sv
  - src/text_buffer.sv
  - src/lcd_timing.sv
  - src/lcd1602.sv
  - src/lcd_text_top.sv
  - target: test
    files:
      - test/tb_lcd_text_top.sv

/* test/lcd_testdata.txt */
# W <host word, 4 hex digits>
# E <row 1, 32 hex digits> <row 2, 32 hex digits>, column 0 in the top byte
W 0048
W 3C5A
W 4061
W 7C21
E 4820202020202020202020202020205A 61202020202020202020202020202021
W 0C2B
W 80A5
W 1C3D
W FFFF
W A123
W D9C0
W 4842
E 3041352B2020203D313233202020205A 61204220394330202020202046464621
W 9FFF
W C0A5
W E7E1
W 2C23
W B000
E 3041352B4646463D313233233030305A 30413520394330203745312046464621
